// File: all.f
design/framer_pkg.sv
design/frame_ram.sv
design/framer_reg_decode.sv
design/mii_tx_path.sv
design/mii_rx_path.sv
design/framer_read_mux.sv
design/mii_framer_top.sv
tb/mii_framer_assert.sv
tb/tb_mii_framer.sv

// File: Makefile
# Verilator lint, build and run for the MII framer testbench

TOP       ?= tb_mii_framer
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal or a failed assertion gives a non-zero exit status
sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_mii_framer.sv
// Testbench for the MII framer with bus access, MII frame driver, transmit monitor and checks
`timescale 1ns/1ps

module tb_mii_framer
   import framer_pkg::*;
();

   localparam int BUF_BYTES = 256;
   localparam int RX_BUFS = 4;
   localparam logic [47:0] OWN_MAC = 48'h02AABBCCDDEE;
   localparam logic [47:0] OTHER_MAC = 48'h02AABBCCDD00;

   logic              clk_mii = 1'b0;
   logic              rstn;
   logic              sel;
   logic              we;
   logic              re;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [3:0]        erxd;
   logic              erx_dv;
   logic [DATA_W-1:0] rdata;
   logic [3:0]        etxd;
   logic              etx_en;
   logic              irq;

   logic [3:0]        tx_nibs [$];
   logic [7:0]        frame_q [$];
   logic [31:0]       lfsr = 32'h15bc73df;
   logic [47:0]       cur_mac;
   logic              cur_promisc;
   logic              cur_loop;
   logic              cur_irq_en;
   logic [1:0]        exp_nb;       // Expected ring pointers
   logic [1:0]        exp_fb;

   mii_framer_top #(.BUF_BYTES(BUF_BYTES), .RX_BUFS(RX_BUFS)) uut (
      .clk_mii  (clk_mii),
      .rstn     (rstn),
      .i_sel    (sel),
      .i_we     (we),
      .i_re     (re),
      .i_addr   (addr),
      .i_wdata  (wdata),
      .i_erxd   (erxd),
      .i_erx_dv (erx_dv),
      .o_rdata  (rdata),
      .o_etxd   (etxd),
      .o_etx_en (etx_en),
      .o_irq    (irq)
   );

   bind mii_framer_top mii_framer_assert u_assert (
      .clk_mii      (clk_mii),
      .rstn         (rstn),
      .i_tx_state   (u_tx.state),
      .i_tx_en      (o_etx_en),
      .i_frame_done (frame_done),
      .i_ring_free  (ring_free),
      .i_irq_en     (irq_en),
      .i_irq        (o_irq)
   );

   always #2 clk_mii = ~clk_mii;

   always @(negedge clk_mii)
   begin
      if (etx_en)
         tx_nibs.push_back(etxd);   // Away from the launching edge
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [7:0] random_byte();
      logic [7:0] b;
      b = '0;
      for (int i = 0; i < 8; i++)
      begin
         lfsr = lfsr_next(lfsr);
         b    = {b[6:0], lfsr[0]};
      end
      return b;
   endfunction

   function automatic logic [47:0] random_mac();
      logic [47:0] m;
      m = '0;
      for (int i = 0; i < 6; i++)
         m = {m[39:0], random_byte()};
      return m;
   endfunction

   // Reference filter and ring rules of the framer
   function automatic logic accept_ref(input logic [47:0] dest, input logic [1:0] nb,
                                       input logic [1:0] fb);
      logic [1:0] after;
      logic       match;
      after = nb + 2'd1;
      match = cur_promisc || dest == cur_mac || dest == 48'hFFFF_FFFF_FFFF ||
              dest[47:24] == 24'h01005E;
      return match && after != fb;
   endfunction

   function automatic logic [31:0] status_ref(input logic [1:0] nb, input logic [1:0] fb);
      logic avail;
      avail = nb != fb;
      return {19'd0, avail & cur_irq_en, 3'd0, avail, 2'd0, nb, 2'd0, fb};
   endfunction

   function automatic logic [31:0] ctrl_word();
      return {13'd0, cur_irq_en, cur_loop, cur_promisc, cur_mac[47:32]};
   endfunction

   task automatic abort_run();
      $display("Something failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic timeout_error(input string what);
      $display("Timeout while waiting for %s", what);
      abort_run();
   endtask

   task automatic compare_word(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
      if (act !== exp)
      begin
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
      begin
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic compare_op(input string name, input reg_op_e exp, input reg_op_e act);
      if (act !== exp)
      begin
         $display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
         abort_run();
      end
   endtask

   task automatic bus_write(input string name, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input reg_op_e exp_op);
      @(posedge clk_mii);
      #0.5;
      sel   = 1'b1;
      we    = 1'b1;
      addr  = a;
      wdata = d;
      #1;
      compare_op({name, " decode"}, exp_op, uut.u_decode.op);
      @(posedge clk_mii);
      #0.5;
      sel = 1'b0;
      we  = 1'b0;
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
      @(posedge clk_mii);
      #0.5;
      sel  = 1'b1;
      re   = 1'b1;
      addr = a;
      @(posedge clk_mii);
      #0.5;
      sel = 1'b0;
      re  = 1'b0;
      d   = rdata;   // Held from the read edge on
   endtask

   task automatic write_ctrl();
      bus_write("mac_hi", 12'(REG_MAC_HI), ctrl_word(), OP_MAC_HI);
   endtask

   task automatic set_firstbuf(input logic [1:0] idx);
      bus_write("firstbuf", 12'(REG_FIRSTBUF), 32'(idx), OP_FIRSTBUF);
      exp_fb = idx;
   endtask

   task automatic wait_status(input string name, input logic [31:0] exp);
      logic [31:0] v;
      int          tries;
      tries = 0;
      bus_read(12'(REG_STATUS), v);
      while (v !== exp && tries < 16)
      begin
         bus_read(12'(REG_STATUS), v);
         tries++;
      end
      compare_word(name, exp, v);
   endtask

   task automatic wait_tx_en(input logic level, input int limit, output int cycles);
      cycles = 0;
      while (etx_en !== level)
      begin
         if (cycles >= limit)
            timeout_error(level ? "o_etx_en to rise" : "o_etx_en to fall");
         @(posedge clk_mii);
         #0.5;
         cycles++;
      end
   endtask

   task automatic build_frame(input logic [47:0] dest, input int len);
      frame_q.delete();
      for (int i = 0; i < 6; i++)
         frame_q.push_back(dest[47 - 8 * i -: 8]);   // Destination goes out first
      for (int i = 6; i < len; i++)
         frame_q.push_back(random_byte());
   endtask

   task automatic drive_frame();
      for (int i = 0; i < 16; i++)
      begin
         @(posedge clk_mii);
         #0.5;
         erx_dv = 1'b1;
         erxd   = (i == 15) ? 4'hD : 4'h5;
      end
      foreach (frame_q[i])
      begin
         @(posedge clk_mii);
         #0.5;
         erxd = frame_q[i][3:0];
         @(posedge clk_mii);
         #0.5;
         erxd = frame_q[i][7:4];
      end
      @(posedge clk_mii);
      #0.5;
      erx_dv = 1'b0;
      erxd   = 4'h0;
   endtask

   task automatic send_tx(input string name);
      int          cycles;
      int          len;
      logic [7:0]  exp_b;
      logic [31:0] v;
      len = frame_q.size();
      foreach (frame_q[i])
         bus_write({name, " buffer"}, {4'h4, 8'(i)}, 32'(frame_q[i]), OP_TX_BUF);
      tx_nibs.delete();
      bus_write({name, " start"}, 12'(REG_TX_LEN), 32'(len), OP_TX_START);
      wait_tx_en(1'b1, 8, cycles);
      compare_word({name, " tx_en delay"}, 32'd2, 32'(cycles));
      wait_tx_en(1'b0, 16 + 2 * len + 8, cycles);
      compare_word({name, " tx_en length"}, 32'(16 + 2 * len), 32'(cycles));
      compare_word({name, " nibble count"}, 32'(16 + 2 * len), 32'(tx_nibs.size()));
      for (int k = 0; k < 8 + len; k++)
      begin
         if (k < 7)
            exp_b = 8'h55;
         else if (k == 7)
            exp_b = 8'hD5;
         else
            exp_b = frame_q[k - 8];
         compare_byte({name, " wire byte"}, exp_b, {tx_nibs[2 * k + 1], tx_nibs[2 * k]});
      end
      bus_read(12'(REG_TX_LEN), v);
      compare_word({name, " tx_len readback"}, 32'(len), v);   // Busy bit clear again
   endtask

   task automatic check_rx(input string name);
      logic [47:0] dest;
      logic        acc;
      logic [1:0]  slot;
      logic [31:0] v;
      dest = {frame_q[0], frame_q[1], frame_q[2], frame_q[3], frame_q[4], frame_q[5]};
      acc  = accept_ref(dest, exp_nb, exp_fb);
      slot = exp_nb;
      if (acc)
         exp_nb = exp_nb + 2'd1;
      repeat (8) @(posedge clk_mii);
      wait_status({name, " status"}, status_ref(exp_nb, exp_fb));
      if (acc)
      begin
         bus_read(12'(REG_RX_LEN_BASE) + 12'(slot), v);
         compare_word({name, " length"}, 32'(frame_q.size()), v);
         foreach (frame_q[i])
         begin
            bus_read({2'b10, slot, 8'(i)}, v);
            compare_byte({name, " byte"}, frame_q[i], v[7:0]);
         end
      end
   endtask

   initial
   begin
      logic [31:0] v;
      rstn        = 1'b0;
      sel         = 1'b0;
      we          = 1'b0;
      re          = 1'b0;
      addr        = '0;
      wdata       = '0;
      erxd        = 4'h0;
      erx_dv      = 1'b0;
      cur_mac     = DEFAULT_MAC;
      cur_promisc = 1'b0;
      cur_loop    = 1'b0;
      cur_irq_en  = 1'b0;
      exp_nb      = 2'd0;
      exp_fb      = 2'd0;
      repeat (10) @(posedge clk_mii);
      #0.5;
      rstn = 1'b1;

      bus_read(12'(REG_MAC_LO), v);
      compare_word("reset mac_lo", DEFAULT_MAC[31:0], v);
      bus_read(12'(REG_MAC_HI), v);
      compare_word("reset mac_hi", ctrl_word(), v);
      bus_read(12'(REG_STATUS), v);
      compare_word("reset status", 32'd0, v);
      cur_mac = OWN_MAC;
      bus_write("mac_lo", 12'(REG_MAC_LO), cur_mac[31:0], OP_MAC_LO);
      write_ctrl();
      bus_read(12'(REG_MAC_LO), v);
      compare_word("mac_lo readback", cur_mac[31:0], v);
      bus_read(12'(REG_MAC_HI), v);
      compare_word("mac_hi readback", ctrl_word(), v);
      bus_write("status write", 12'(REG_STATUS), 32'hFFFF_FFFF, OP_NONE);
      bus_read(12'(REG_STATUS), v);
      compare_word("status read-only", status_ref(exp_nb, exp_fb), v);

      build_frame(random_mac(), 20);
      send_tx("tx_random");

      build_frame(OWN_MAC, 24);
      drive_frame();
      check_rx("rx_unicast");
      build_frame(OTHER_MAC, 16);
      drive_frame();
      check_rx("rx_other");
      build_frame(48'hFFFF_FFFF_FFFF, 20);
      drive_frame();
      check_rx("rx_broadcast");
      build_frame(48'h01005E000042, 18);
      drive_frame();
      check_rx("rx_multicast");
      set_firstbuf(exp_nb);
      cur_promisc = 1'b1;
      write_ctrl();
      build_frame(OTHER_MAC, 16);
      drive_frame();
      check_rx("rx_promisc");
      cur_promisc = 1'b0;
      write_ctrl();

      set_firstbuf(exp_nb);
      cur_irq_en = 1'b1;
      write_ctrl();
      wait_status("irq idle status", status_ref(exp_nb, exp_fb));
      compare_word("irq idle", 32'd0, 32'(irq));
      build_frame(OWN_MAC, 16);
      drive_frame();
      check_rx("rx_irq");
      compare_word("irq raised", 32'd1, 32'(irq));
      set_firstbuf(exp_nb);
      wait_status("irq cleared status", status_ref(exp_nb, exp_fb));
      compare_word("irq cleared", 32'd0, 32'(irq));
      for (int n = 0; n < RX_BUFS; n++)
      begin
         build_frame(OWN_MAC, 14);
         drive_frame();
         check_rx("rx_fill");   // Last one finds the ring full
      end
      bus_read(12'(REG_STATUS), v);
      compare_word("ring full", status_ref(exp_fb - 2'd1, exp_fb), v);   // One slot left empty
      compare_word("irq while full", 32'd1, 32'(irq));

      set_firstbuf(exp_nb);
      cur_irq_en = 1'b0;
      cur_loop   = 1'b1;
      write_ctrl();
      build_frame(OWN_MAC, 18);
      send_tx("tx_loopback");
      check_rx("rx_loopback");
      cur_loop = 1'b0;
      write_ctrl();

      $display("Everything OK");
      $finish;
   end

endmodule

// File: tb/mii_framer_assert.sv
// Bound checks on the MII framer transmit enable, receive ring and interrupt
`timescale 1ns/1ps

module mii_framer_assert
   import framer_pkg::*;
(
   input logic      clk_mii,
   input logic      rstn,
   input tx_state_e i_tx_state,
   input logic      i_tx_en,
   input logic      i_frame_done,
   input logic      i_ring_free,
   input logic      i_irq_en,
   input logic      i_irq
);

   // Transmit enable is only driven outside the idle state
   a_idle_quiet: assert property (@(posedge clk_mii) disable iff (!rstn)
      (i_tx_state == TX_IDLE) |-> !i_tx_en)
      else $error("o_etx_en is high while the transmitter is idle");

   // nextbuf only advances when the slot after it is not firstbuf
   a_ring_advance: assert property (@(posedge clk_mii) disable iff (!rstn)
      i_frame_done |-> i_ring_free)
      else $error("nextbuf advanced into firstbuf");

   a_irq_masked: assert property (@(posedge clk_mii) disable iff (!rstn)
      !$past(i_irq_en) |-> !i_irq)   // Interrupt is registered one cycle behind irq_en
      else $error("o_irq is high while irq_en is low");

endmodule

// File: design/mii_framer_top.sv
// MII Ethernet framer top: register decode, transmit and receive paths, buffers and loopback
`timescale 1ns/1ps

module mii_framer_top
   import framer_pkg::*;
#(
   parameter int BUF_BYTES = 256,
   parameter int RX_BUFS = 4
)
(
   input  logic              clk_mii,
   input  logic              rstn,
   input  logic              i_sel,
   input  logic              i_we,
   input  logic              i_re,
   input  logic [ADDR_W-1:0] i_addr,
   input  logic [DATA_W-1:0] i_wdata,
   input  logic [3:0]        i_erxd,
   input  logic              i_erx_dv,
   output logic [DATA_W-1:0] o_rdata,
   output logic [3:0]        o_etxd,
   output logic              o_etx_en,
   output logic              o_irq
);

   localparam int AW = $clog2(BUF_BYTES);
   localparam int LEN_W = AW + 1;
   localparam int PW = $clog2(RX_BUFS);

   logic [47:0]      mac_addr;
   logic             promisc, loopback, irq_en;
   logic             tx_start, tx_busy;
   logic [LEN_W-1:0] tx_len;
   logic             txram_we;
   logic [AW-1:0]    txram_addr, tx_rd_addr;
   logic [7:0]       txram_data, tx_rd_data;
   logic [PW-1:0]    firstbuf, nextbuf;
   logic             ring_free, avail, frame_done;
   logic             rxram_we, len_we;
   logic [PW+AW-1:0] rxram_addr, rx_rd_addr;
   logic [7:0]       rxram_data, rx_rd_data;
   logic [LEN_W-1:0] len_data;
   logic [3:0]       rxd_q;
   logic             rx_dv_q;

   // Receive input stage, shared by the PHY and the loopback path
   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
         rx_dv_q <= 1'b0;
      else
         rx_dv_q <= loopback ? o_etx_en : i_erx_dv;
   end

   always_ff @(posedge clk_mii)
   begin
      rxd_q <= loopback ? o_etxd : i_erxd;
   end

   framer_reg_decode #(.BUF_BYTES(BUF_BYTES), .RX_BUFS(RX_BUFS)) u_decode (
      .clk_mii      (clk_mii),
      .rstn         (rstn),
      .i_sel        (i_sel),
      .i_we         (i_we),
      .i_addr       (i_addr),
      .i_wdata      (i_wdata),
      .i_frame_done (frame_done),
      .o_mac_addr   (mac_addr),
      .o_promisc    (promisc),
      .o_loopback   (loopback),
      .o_irq_en     (irq_en),
      .o_tx_start   (tx_start),
      .o_tx_len     (tx_len),
      .o_txram_we   (txram_we),
      .o_txram_addr (txram_addr),
      .o_txram_data (txram_data),
      .o_firstbuf   (firstbuf),
      .o_nextbuf    (nextbuf),
      .o_ring_free  (ring_free),
      .o_avail      (avail),
      .o_irq        (o_irq)
   );

   frame_ram #(.DEPTH(BUF_BYTES)) u_tx_ram (
      .clk_mii (clk_mii),
      .i_we    (txram_we),
      .i_waddr (txram_addr),
      .i_wdata (txram_data),
      .i_raddr (tx_rd_addr),
      .o_rdata (tx_rd_data)
   );

   mii_tx_path #(.BUF_BYTES(BUF_BYTES)) u_tx (
      .clk_mii    (clk_mii),
      .rstn       (rstn),
      .i_tx_start (tx_start),
      .i_tx_len   (tx_len),
      .i_ram_data (tx_rd_data),
      .o_ram_addr (tx_rd_addr),
      .o_txd      (o_etxd),
      .o_tx_en    (o_etx_en),
      .o_tx_busy  (tx_busy)
   );

   mii_rx_path #(.BUF_BYTES(BUF_BYTES), .RX_BUFS(RX_BUFS)) u_rx (
      .clk_mii      (clk_mii),
      .rstn         (rstn),
      .i_rxd        (rxd_q),
      .i_rx_dv      (rx_dv_q),
      .i_mac_addr   (mac_addr),
      .i_promisc    (promisc),
      .i_ring_free  (ring_free),
      .i_nextbuf    (nextbuf),
      .o_ram_we     (rxram_we),
      .o_ram_addr   (rxram_addr),
      .o_ram_data   (rxram_data),
      .o_frame_done (frame_done),
      .o_len_we     (len_we),
      .o_len_data   (len_data)
   );

   frame_ram #(.DEPTH(BUF_BYTES * RX_BUFS)) u_rx_ram (
      .clk_mii (clk_mii),
      .i_we    (rxram_we),
      .i_waddr (rxram_addr),
      .i_wdata (rxram_data),
      .i_raddr (rx_rd_addr),
      .o_rdata (rx_rd_data)
   );

   framer_read_mux #(.BUF_BYTES(BUF_BYTES), .RX_BUFS(RX_BUFS)) u_read (
      .clk_mii      (clk_mii),
      .rstn         (rstn),
      .i_sel        (i_sel),
      .i_re         (i_re),
      .i_addr       (i_addr),
      .i_mac_addr   (mac_addr),
      .i_promisc    (promisc),
      .i_loopback   (loopback),
      .i_irq_en     (irq_en),
      .i_tx_busy    (tx_busy),
      .i_tx_len     (tx_len),
      .i_irq        (o_irq),
      .i_avail      (avail),
      .i_nextbuf    (nextbuf),
      .i_firstbuf   (firstbuf),
      .i_len_we     (len_we),
      .i_len_data   (len_data),
      .i_rxram_data (rx_rd_data),
      .o_rxram_addr (rx_rd_addr),
      .o_rdata      (o_rdata)
   );

endmodule

// File: design/framer_read_mux.sv
// Bus readback for the MII framer: register words, receive lengths and receive buffer bytes
`timescale 1ns/1ps

module framer_read_mux
   import framer_pkg::*;
#(
   parameter int BUF_BYTES = 256,
   parameter int RX_BUFS = 4,
   localparam int AW = $clog2(BUF_BYTES),
   localparam int LEN_W = AW + 1,
   localparam int PW = $clog2(RX_BUFS)
)
(
   input  logic              clk_mii,
   input  logic              rstn,
   input  logic              i_sel,
   input  logic              i_re,
   input  logic [ADDR_W-1:0] i_addr,
   input  logic [47:0]       i_mac_addr,
   input  logic              i_promisc,
   input  logic              i_loopback,
   input  logic              i_irq_en,
   input  logic              i_tx_busy,
   input  logic [LEN_W-1:0]  i_tx_len,
   input  logic              i_irq,
   input  logic              i_avail,
   input  logic [PW-1:0]     i_nextbuf,
   input  logic [PW-1:0]     i_firstbuf,
   input  logic              i_len_we,
   input  logic [LEN_W-1:0]  i_len_data,
   input  logic [7:0]        i_rxram_data,
   output logic [PW+AW-1:0]  o_rxram_addr,
   output logic [DATA_W-1:0] o_rdata
);

   logic [LEN_W-1:0]  lens [RX_BUFS];
   logic              rd;
   logic [PW+AW-1:0]  rx_addr;
   logic [PW+AW-1:0]  addr_q;
   logic [DATA_W-1:0] reg_word;
   logic [DATA_W-1:0] rdata_q;
   logic              rx_sel_q;

   assign rd      = i_sel & i_re;
   assign rx_addr = {i_addr[8+PW-1:8], i_addr[AW-1:0]};

   always_ff @(posedge clk_mii)
   begin
      if (i_len_we)
         lens[i_nextbuf] <= i_len_data;
   end

   always_comb
   begin
      reg_word = '0;
      if (i_addr[ADDR_W-1:4] == '0)
      begin
         if (i_addr[3:0] >= REG_RX_LEN_BASE && i_addr[3:0] < REG_RX_LEN_BASE + RX_BUFS)
            reg_word = DATA_W'(lens[i_addr[PW-1:0]]);
         else
         begin
            case (i_addr[3:0])
               REG_MAC_LO:   reg_word = i_mac_addr[31:0];
               REG_MAC_HI:   reg_word = DATA_W'({i_irq_en, i_loopback, i_promisc,
                                                 i_mac_addr[47:32]});
               REG_TX_LEN:   reg_word = {i_tx_busy, (DATA_W-1)'(i_tx_len)};
               REG_STATUS:   reg_word = DATA_W'({i_irq, 3'b000, i_avail,
                                                 4'(i_nextbuf), 4'(i_firstbuf)});
               REG_FIRSTBUF: reg_word = DATA_W'(i_firstbuf);
               default:      reg_word = '0;
            endcase
         end
      end
   end

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         rdata_q  <= '0;
         rx_sel_q <= 1'b0;
      end
      else if (rd)
      begin
         rdata_q  <= reg_word;
         rx_sel_q <= i_addr[ADDR_W-1:10] == RX_WIN_TAG;
      end
   end

   always_ff @(posedge clk_mii)
   begin
      if (rd)
         addr_q <= rx_addr;
   end

   // Keep the RAM on the last read address so its byte holds until the next read
   assign o_rxram_addr = rd ? rx_addr : addr_q;
   assign o_rdata      = rx_sel_q ? DATA_W'(i_rxram_data) : rdata_q;

endmodule

// File: design/mii_rx_path.sv
// MII receiver: SFD search, byte assembly, destination filter and receive ring writes
`timescale 1ns/1ps

module mii_rx_path
   import framer_pkg::*;
#(
   parameter int BUF_BYTES = 256,
   parameter int RX_BUFS = 4,
   localparam int AW = $clog2(BUF_BYTES),
   localparam int LEN_W = AW + 1,
   localparam int PW = $clog2(RX_BUFS)
)
(
   input  logic             clk_mii,
   input  logic             rstn,
   input  logic [3:0]       i_rxd,
   input  logic             i_rx_dv,
   input  logic [47:0]      i_mac_addr,
   input  logic             i_promisc,
   input  logic             i_ring_free,
   input  logic [PW-1:0]    i_nextbuf,
   output logic             o_ram_we,
   output logic [PW+AW-1:0] o_ram_addr,
   output logic [7:0]       o_ram_data,
   output logic             o_frame_done,
   output logic             o_len_we,
   output logic [LEN_W-1:0] o_len_data
);

   rx_state_e        state;
   logic             ph;         // High on the high nibble of a byte
   logic [3:0]       lo;
   logic [LEN_W-1:0] cnt;        // Bytes received so far
   logic [47:0]      dest;
   logic [47:0]      dest_next;
   logic             accept;

   assign dest_next = {dest[39:0], i_rxd, lo};
   assign accept    = i_ring_free &&
                      (i_promisc || dest_next == i_mac_addr || (&dest_next) ||
                       dest_next[47:24] == 24'h01005E);
   assign o_len_data = cnt;

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         state        <= RX_IDLE;
         ph           <= 1'b0;
         cnt          <= '0;
         o_ram_we     <= 1'b0;
         o_len_we     <= 1'b0;
         o_frame_done <= 1'b0;
      end
      else
      begin
         o_ram_we     <= 1'b0;
         o_len_we     <= 1'b0;
         o_frame_done <= o_len_we;   // Ring advances after the length is stored
         case (state)
            RX_IDLE:
               if (i_rx_dv)
                  state <= RX_PREAMBLE;
            RX_PREAMBLE:
            begin
               ph  <= 1'b0;
               cnt <= '0;
               if (!i_rx_dv)
                  state <= RX_IDLE;
               else if (i_rxd == 4'hD)
                  state <= RX_HDR;
            end
            RX_HDR, RX_DATA:
            begin
               if (!i_rx_dv)
               begin
                  o_len_we <= state == RX_DATA;   // Runts are dropped silently
                  state    <= RX_IDLE;
               end
               else
               begin
                  ph <= ~ph;
                  if (ph)
                  begin
                     o_ram_we <= 1'b1;
                     cnt      <= cnt + 1'b1;
                     if (state == RX_HDR && cnt == LEN_W'(5))
                        state <= accept ? RX_DATA : RX_DROP;
                  end
               end
            end
            RX_DROP:
               if (!i_rx_dv)
                  state <= RX_IDLE;
            default:
               state <= RX_IDLE;
         endcase
      end
   end

   // Byte path, written into the free slot at nextbuf whether or not it is kept
   always_ff @(posedge clk_mii)
   begin
      if (!ph)
         lo <= i_rxd;
      else
      begin
         o_ram_data <= {i_rxd, lo};
         o_ram_addr <= {i_nextbuf, cnt[AW-1:0]};
         if (state == RX_HDR)
            dest <= dest_next;
      end
   end

endmodule

// File: design/mii_tx_path.sv
// MII transmitter: preamble, SFD and buffered payload sent low nibble first
`timescale 1ns/1ps

module mii_tx_path
   import framer_pkg::*;
#(
   parameter int BUF_BYTES = 256,
   localparam int AW = $clog2(BUF_BYTES),
   localparam int LEN_W = AW + 1
)
(
   input  logic             clk_mii,
   input  logic             rstn,
   input  logic             i_tx_start,
   input  logic [LEN_W-1:0] i_tx_len,
   input  logic [7:0]       i_ram_data,
   output logic [AW-1:0]    o_ram_addr,
   output logic [3:0]       o_txd,
   output logic             o_tx_en,
   output logic             o_tx_busy
);

   tx_state_e        state;
   logic [LEN_W:0]   cnt;        // Nibble counter
   logic [LEN_W-1:0] len;
   logic [LEN_W:0]   last_nib;

   assign last_nib = {len, 1'b0} - 1'b1;

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         state      <= TX_IDLE;
         cnt        <= '0;
         o_ram_addr <= '0;
         o_txd      <= 4'h0;
         o_tx_en    <= 1'b0;
         o_tx_busy  <= 1'b0;
      end
      else
      begin
         case (state)
            TX_IDLE:
            begin
               o_tx_busy <= 1'b0;
               if (i_tx_start && !o_tx_busy)
               begin
                  state      <= TX_PREAMBLE;
                  o_tx_busy  <= 1'b1;
                  cnt        <= '0;
                  o_ram_addr <= '0;   // First byte is fetched during the preamble
               end
            end
            TX_PREAMBLE:
            begin
               o_tx_en <= 1'b1;
               o_txd   <= (cnt[3:0] == 4'hF) ? 4'hD : 4'h5;   // Last nibble of 0xD5
               cnt     <= cnt + 1'b1;
               if (cnt[3:0] == 4'hF)
               begin
                  cnt   <= '0;
                  state <= (len == '0) ? TX_DONE : TX_DATA;
               end
            end
            TX_DATA:
            begin
               o_txd <= cnt[0] ? i_ram_data[7:4] : i_ram_data[3:0];
               cnt   <= cnt + 1'b1;
               if (!cnt[0])
                  o_ram_addr <= o_ram_addr + 1'b1;   // Next byte lands before its low nibble
               if (cnt == last_nib)
                  state <= TX_DONE;
            end
            TX_DONE:
            begin
               o_tx_en <= 1'b0;
               state   <= TX_IDLE;
            end
            default:
               state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_mii)
   begin
      if (state == TX_IDLE && i_tx_start && !o_tx_busy)
         len <= i_tx_len;
   end

endmodule

// File: design/framer_reg_decode.sv
// Bus write decode for the MII framer: control registers, transmit buffer writes, receive ring
`timescale 1ns/1ps

module framer_reg_decode
   import framer_pkg::*;
#(
   parameter int BUF_BYTES = 256,
   parameter int RX_BUFS = 4,
   localparam int AW = $clog2(BUF_BYTES),
   localparam int LEN_W = AW + 1,
   localparam int PW = $clog2(RX_BUFS)
)
(
   input  logic              clk_mii,
   input  logic              rstn,
   input  logic              i_sel,
   input  logic              i_we,
   input  logic [ADDR_W-1:0] i_addr,
   input  logic [DATA_W-1:0] i_wdata,
   input  logic              i_frame_done,
   output logic [47:0]       o_mac_addr,
   output logic              o_promisc,
   output logic              o_loopback,
   output logic              o_irq_en,
   output logic              o_tx_start,
   output logic [LEN_W-1:0]  o_tx_len,
   output logic              o_txram_we,
   output logic [AW-1:0]     o_txram_addr,
   output logic [7:0]        o_txram_data,
   output logic [PW-1:0]     o_firstbuf,
   output logic [PW-1:0]     o_nextbuf,
   output logic              o_ring_free,
   output logic              o_avail,
   output logic              o_irq
);

   reg_op_e       op;
   logic [PW-1:0] next_slot;

   always_comb
   begin
      op = OP_NONE;
      if (i_sel && i_we)
      begin
         if (i_addr[ADDR_W-1:8] == TX_WIN_TAG)
            op = OP_TX_BUF;
         else if (i_addr[ADDR_W-1:4] == '0)
         begin
            case (i_addr[3:0])
               REG_MAC_LO:   op = OP_MAC_LO;
               REG_MAC_HI:   op = OP_MAC_HI;
               REG_TX_LEN:   op = OP_TX_START;
               REG_FIRSTBUF: op = OP_FIRSTBUF;
               default:      op = OP_NONE;   // Status and lengths are read-only
            endcase
         end
      end
   end

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         o_mac_addr <= DEFAULT_MAC;
         o_promisc  <= 1'b0;
         o_loopback <= 1'b0;
         o_irq_en   <= 1'b0;
         o_tx_start <= 1'b0;
         o_tx_len   <= '0;
         o_firstbuf <= '0;
         o_nextbuf  <= '0;
         o_irq      <= 1'b0;
      end
      else
      begin
         o_tx_start <= 1'b0;
         o_irq      <= o_avail & o_irq_en;
         if (i_frame_done)
            o_nextbuf <= next_slot;   // Publish the slot just filled
         case (op)
            OP_MAC_LO:
               o_mac_addr[31:0] <= i_wdata[31:0];
            OP_MAC_HI:
            begin
               o_mac_addr[47:32] <= i_wdata[15:0];
               o_promisc         <= i_wdata[16];
               o_loopback        <= i_wdata[17];
               o_irq_en          <= i_wdata[18];
            end
            OP_TX_START:
            begin
               o_tx_len   <= i_wdata[LEN_W-1:0];
               o_tx_start <= 1'b1;
            end
            OP_FIRSTBUF:
               o_firstbuf <= i_wdata[PW-1:0];   // Host has consumed buffers up to here
            default:
               ;
         endcase
      end
   end

   assign next_slot   = o_nextbuf + 1'b1;
   assign o_avail     = o_nextbuf != o_firstbuf;
   assign o_ring_free = next_slot != o_firstbuf;   // One slot stays empty

   assign o_txram_we   = op == OP_TX_BUF;
   assign o_txram_addr = i_addr[AW-1:0];
   assign o_txram_data = i_wdata[7:0];

endmodule

// File: design/frame_ram.sv
// Frame buffer RAM with one write port and one registered read port
`timescale 1ns/1ps

module frame_ram
#(
   parameter int DEPTH = 256,
   localparam int AW = $clog2(DEPTH)
)
(
   input  logic          clk_mii,
   input  logic          i_we,
   input  logic [AW-1:0] i_waddr,
   input  logic [7:0]    i_wdata,
   input  logic [AW-1:0] i_raddr,
   output logic [7:0]    o_rdata
);

   logic [7:0] mem [DEPTH];

   always_ff @(posedge clk_mii)
   begin
      if (i_we)
         mem[i_waddr] <= i_wdata;
      o_rdata <= mem[i_raddr];   // One cycle read latency
   end

endmodule

// File: design/framer_pkg.sv
// MII framer shared definitions: register map, address windows and the state and opcode types
package framer_pkg;

   localparam logic [47:0] DEFAULT_MAC = 48'h230100890702;

   localparam int ADDR_W = 12;
   localparam int DATA_W = 32;

   // Register word indices, valid when address bits 11:4 are clear
   localparam logic [3:0] REG_MAC_LO      = 4'd0;
   localparam logic [3:0] REG_MAC_HI      = 4'd1;   // MAC 47:32, promisc 16, loopback 17, irq_en 18
   localparam logic [3:0] REG_TX_LEN      = 4'd2;   // Write starts transmission
   localparam logic [3:0] REG_STATUS      = 4'd3;   // irq 12, avail 8, nextbuf 7:4, firstbuf 3:0
   localparam logic [3:0] REG_FIRSTBUF    = 4'd4;
   localparam logic [3:0] REG_RX_LEN_BASE = 4'd8;

   // Window tags on the upper address bits
   localparam logic [3:0] TX_WIN_TAG = 4'h4;        // Bits 11:8, 0x400 to 0x4FF
   localparam logic [1:0] RX_WIN_TAG = 2'b10;       // Bits 11:10, 0x800 to 0xBFF

   typedef enum logic [2:0] {
      OP_NONE,
      OP_MAC_LO,
      OP_MAC_HI,
      OP_TX_START,
      OP_FIRSTBUF,
      OP_TX_BUF
   } reg_op_e;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_PREAMBLE,
      TX_DATA,
      TX_DONE
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_PREAMBLE,
      RX_HDR,
      RX_DATA,
      RX_DROP
   } rx_state_e;

endpackage
